//--- tb.f
+incdir+tb
src/tgen_pkg.sv
src/tgen_stream_if.sv
src/tgen_cfg_regs.sv
src/tgen_reservoir.sv
src/tgen_emitter.sv
src/tgen_top.sv
tb/tb_tgen.sv

//--- tb/tgen_tb_ref.svh
`ifndef TGEN_TB_REF_SVH
`define TGEN_TB_REF_SVH

  // word k of a fill is the seed advanced k+1 galois steps
  function automatic logic [DATA_W-1:0] fill_word(input logic [DATA_W-1:0] seed,
                                                  input int                k);
    logic [DATA_W-1:0] s;
    logic              lsb;
    s = seed;
    for (int j = 0; j <= k; j++) begin
      lsb = s[0];              // bit about to fall off
      s   = s >> 1;
      if (lsb) s = s ^ FILL_POLY;  // taps only on a shifted-out one
    end
    return s;
  endfunction

  // strobe of the armed beat, low rot bytes dropped
  function automatic logic [STRB_W-1:0] exp_strb(input int rot);
    logic [STRB_W-1:0] m;
    m = '1;
    return m << rot;
  endfunction

  // plain 32-bit lcg, upper bits are the useful ones
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

`endif

//--- tb/tb_tgen.sv
`default_nettype none

module tb_tgen
  import tgen_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  `include "tgen_tb_ref.svh"

  localparam int LIMIT = 2000;  // cycles allowed per wait

  logic              clk_i;
  logic              reset_i;
  logic              cfg_we_i;
  logic [CFG_AW-1:0] cfg_addr_i;
  logic [DATA_W-1:0] cfg_wdata_i;
  logic [DATA_W-1:0] cfg_rdata_o;
  logic [DATA_W-1:0] stream_data_o;
  logic [STRB_W-1:0] stream_strb_o;
  logic              stream_valid_o;
  logic              stream_ready_i;

  logic              rand_ready;   // ready from lcg, else held high
  logic [31:0]       lcg_q;
  logic [DATA_W-1:0] exp_seed;     // seed of the current reservoir
  int                beat_idx;     // beats since the last fill
  int                acc_cnt;      // all accepted beats
  logic              hold_chk;     // back-pressure check armed
  logic              held_q;       // last edge saw valid without ready
  logic [DATA_W-1:0] held_data;
  logic              rot_pend;     // masked strobe beat still owed
  int                rot_val;
  int                rot_left;     // full beats still allowed before it
  logic [DATA_W-1:0] rdval;

  tgen_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns
  end

  always @(negedge clk_i) begin
    lcg_q = lcg_next(lcg_q);
    stream_ready_i = rand_ready ? lcg_q[16] : 1'b1;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic timed_out(input string what);
    $display("timed out waiting for %s", what);
    abort_run();
  endtask

  task automatic check_data(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_strb(input string what, input logic [STRB_W-1:0] got,
                            input logic [STRB_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(input string what, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      abort_run();
    end
  endtask

  task automatic reg_write(input logic [CFG_AW-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk_i);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic reg_read(input logic [CFG_AW-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk_i);
    cfg_addr_i = addr;
    @(negedge clk_i);
    data = cfg_rdata_o;  // registered, one edge later
  endtask

  task automatic wait_fill(input logic level);
    logic [DATA_W-1:0] v;
    int                n = 0;
    reg_read(ADDR_STATUS, v);
    while (v[0] !== level) begin
      n++;
      if (n > LIMIT) timed_out("the fill_busy status bit");
      reg_read(ADDR_STATUS, v);
    end
  endtask

  task automatic wait_beats(input int n);
    int target = acc_cnt + n;
    int t = 0;
    while (acc_cnt < target) begin
      @(negedge clk_i);
      t++;
      if (t > LIMIT) timed_out("accepted stream beats");
    end
  endtask

  task automatic wait_idle();
    int t = 0;
    while (stream_valid_o !== 1'b0) begin
      @(negedge clk_i);
      t++;
      if (t > LIMIT) timed_out("the stream to go idle");
    end
  endtask

  // stream idle on entry, leaves it enabled without stalls
  task automatic refill(input logic [DATA_W-1:0] seed);
    reg_write(ADDR_SEED, seed);
    reg_write(ADDR_CTRL, 32'h1 << CTRL_RAND_BIT);
    wait_fill(1'b1);
    wait_fill(1'b0);
    beat_idx = 0;
    exp_seed = seed;
    reg_write(ADDR_CTRL, 32'h3);  // enable + no_stall
    hold_chk = 1'b1;
  endtask

  // scoreboard, sees pre-edge values on every rising edge
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (hold_chk && held_q) begin
        if (stream_valid_o !== 1'b1) begin
          $display("FAIL stream_valid_o: got 0x%h, expected 0x1", stream_valid_o);
          abort_run();
        end
        check_data("stream_data_o held", stream_data_o, held_data);
      end
      held_q    = stream_valid_o && !stream_ready_i;
      held_data = stream_data_o;
      if (stream_valid_o && stream_ready_i) begin
        check_data("stream_data_o", stream_data_o, fill_word(exp_seed, beat_idx % RES_DEPTH));
        if (rot_pend && stream_strb_o !== '1) begin
          check_strb("stream_strb_o", stream_strb_o, exp_strb(rot_val));
          rot_pend = 1'b0;
        end else begin
          check_strb("stream_strb_o", stream_strb_o, '1);
          if (rot_pend && rot_left == 0) begin
            $display("masked strobe beat did not follow the rotation write in time");
            abort_run();
          end
          if (rot_pend) rot_left--;
        end
        beat_idx++;
        acc_cnt++;
      end
    end
  end

  initial begin
    reset_i        = 1'b1;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_wdata_i    = '0;
    stream_ready_i = 1'b1;
    rand_ready     = 1'b0;
    lcg_q          = 32'd8113;
    exp_seed       = '0;
    beat_idx       = 0;
    acc_cnt        = 0;
    hold_chk       = 1'b0;
    held_q         = 1'b0;
    held_data      = '0;
    rot_pend       = 1'b0;
    rot_val        = 0;
    rot_left       = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      if (stream_valid_o !== 1'b0) begin
        $display("FAIL stream_valid_o: got 0x%h, expected 0x0", stream_valid_o);
        abort_run();
      end
    end
    reg_read(ADDR_STATUS, rdval);
    check_reg("cfg_rdata_o status after reset", rdval, '0);
    refill(32'h1234_5678);
    wait_beats(40);              // wraps the reservoir twice
    reg_write(ADDR_STALL, 32'd128);
    rand_ready = 1'b1;
    reg_write(ADDR_CTRL, 32'h1);  // stalls on
    wait_beats(60);
    for (int r = 1; r <= 3; r++) begin
      rot_val  = r;
      rot_left = 4;              // beats already in flight pass unmasked
      rot_pend = 1'b1;
      reg_write(ADDR_ROT, r);
      wait_beats(12);
      if (rot_pend) begin
        $display("no masked strobe beat seen after rotation write %0d", r);
        abort_run();
      end
    end
    hold_chk = 1'b0;             // disable may drop a held beat
    reg_write(ADDR_CTRL, 32'h0);
    wait_idle();
    reg_read(ADDR_STATUS, rdval);
    check_reg("cfg_rdata_o status beat count", rdval,
              {BCNT_W'(acc_cnt), {(DATA_W-BCNT_W){1'b0}}});
    rand_ready = 1'b0;
    refill(32'hC0DE_F00D);       // must restart at word 0
    wait_beats(20);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/tgen_top.sv
`default_nettype none

module tgen_top
  import tgen_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              cfg_we_i,
  input  wire logic [CFG_AW-1:0] cfg_addr_i,
  input  wire logic [DATA_W-1:0] cfg_wdata_i,
  output logic      [DATA_W-1:0] cfg_rdata_o,
  output logic      [DATA_W-1:0] stream_data_o,
  output logic      [STRB_W-1:0] stream_strb_o,
  output logic                   stream_valid_o,
  input  wire logic              stream_ready_i
);

  logic              enable;
  logic              no_stall;
  logic [7:0]        stall_thresh;
  logic [1:0]        rot_amount;
  logic              rot_arm;       // pulse
  logic              fill_start;    // pulse
  logic [DATA_W-1:0] seed;
  logic              fill_busy;
  logic [RES_AW-1:0] rd_idx;
  logic [DATA_W-1:0] rd_word;
  logic              beat_done;

  tgen_stream_if str_if ();

  // sink side of the stream maps to plain ports
  assign stream_data_o  = str_if.data;
  assign stream_strb_o  = str_if.strb;
  assign stream_valid_o = str_if.valid;
  assign str_if.ready   = stream_ready_i;

  tgen_cfg_regs u_regs (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .fill_busy_i    (fill_busy),
    .beat_done_i    (beat_done),
    .enable_o       (enable),
    .no_stall_o     (no_stall),
    .stall_thresh_o (stall_thresh),
    .rot_amount_o   (rot_amount),
    .rot_arm_o      (rot_arm),
    .fill_start_o   (fill_start),
    .seed_o         (seed)
  );

  tgen_reservoir u_res (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fill_start_i (fill_start),
    .seed_i       (seed),
    .fill_busy_o  (fill_busy),
    .rd_idx_i     (rd_idx),
    .rd_word_o    (rd_word)
  );

  tgen_emitter u_emit (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .enable_i       (enable),
    .no_stall_i     (no_stall),
    .stall_thresh_i (stall_thresh),
    .rot_amount_i   (rot_amount),
    .rot_arm_i      (rot_arm),
    .fill_busy_i    (fill_busy),
    .rd_word_i      (rd_word),
    .rd_idx_o       (rd_idx),
    .beat_done_o    (beat_done),
    .str            (str_if.source)
  );

endmodule

`default_nettype wire

//--- src/tgen_emitter.sv
`default_nettype none

module tgen_emitter
  import tgen_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              enable_i,
  input  wire logic              no_stall_i,
  input  wire logic [7:0]        stall_thresh_i,
  input  wire logic [1:0]        rot_amount_i,
  input  wire logic              rot_arm_i,
  input  wire logic              fill_busy_i,
  input  wire logic [DATA_W-1:0] rd_word_i,
  output logic      [RES_AW-1:0] rd_idx_o,
  output logic                   beat_done_o,
  tgen_stream_if.source          str
);

  logic [DATA_W-1:0] data_q;      // output payload
  logic [STRB_W-1:0] strb_q;
  logic              valid_q;
  logic [RES_AW-1:0] idx_q;       // next reservoir word to load
  logic [RES_AW-1:0] idx_inc;
  logic [15:0]       stall_lfsr_q;
  logic              rot_pend_q;  // next valid load gets masked strobe
  logic [STRB_W-1:0] rot_strb;
  logic              run;         // enabled and reservoir stable
  logic              load_ok;     // output register may take a new beat
  logic              stall;
  logic              xfer;

  assign run     = enable_i && !fill_busy_i;
  assign load_ok = run && (!valid_q || str.ready);
  assign xfer    = valid_q && str.ready;
  assign stall   = !no_stall_i && (stall_lfsr_q[7:0] < stall_thresh_i);
  assign idx_inc = (idx_q == RES_AW'(RES_DEPTH - 1)) ? '0 : idx_q + 1'b1;  // wrap

  // low bytes below rot_amount are masked off
  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      rot_strb[i] = (i >= int'(rot_amount_i));
    end
  end

  // stall lfsr, one step per load opportunity
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stall_lfsr_q <= STALL_INIT;
    end else if (load_ok) begin
      stall_lfsr_q <= (stall_lfsr_q >> 1) ^ (stall_lfsr_q[0] ? STALL_POLY : 16'h0);
    end
  end

  // control: valid, index, rotation flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q    <= 1'b0;
      idx_q      <= '0;
      rot_pend_q <= 1'b0;
    end else begin
      if (fill_busy_i) begin
        valid_q <= 1'b0;
        idx_q   <= '0;                    // restart at word 0 after fill
      end else if (!enable_i) begin
        valid_q <= 1'b0;                  // index held while disabled
      end else if (load_ok) begin
        valid_q <= !stall;
        if (!stall) begin
          idx_q      <= idx_inc;
          rot_pend_q <= 1'b0;
        end
      end
      if (rot_arm_i) rot_pend_q <= 1'b1;  // arm wins over a same-cycle load
    end
  end

  // payload, held under back-pressure and across stalls
  always_ff @(posedge clk_i) begin
    if (load_ok && !stall) begin
      data_q <= rd_word_i;
      strb_q <= rot_pend_q ? rot_strb : '1;
    end
  end

  assign str.data    = data_q;
  assign str.strb    = strb_q;
  assign str.valid   = valid_q;
  assign rd_idx_o    = idx_q;
  assign beat_done_o = xfer;  // counted in the status word

endmodule

`default_nettype wire

//--- src/tgen_reservoir.sv
`default_nettype none

module tgen_reservoir
  import tgen_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              fill_start_i,
  input  wire logic [DATA_W-1:0] seed_i,
  output logic                   fill_busy_o,
  input  wire logic [RES_AW-1:0] rd_idx_i,
  output logic      [DATA_W-1:0] rd_word_o
);

  logic [DATA_W-1:0] mem_q [RES_DEPTH];  // the word store
  logic [DATA_W-1:0] lfsr_q;             // fill lfsr state
  logic [DATA_W-1:0] lfsr_next;
  logic [RES_AW-1:0] fill_idx_q;         // next word to write
  logic              busy_q;

  // one galois step, right shift with conditional tap xor
  function automatic logic [DATA_W-1:0] fill_step(input logic [DATA_W-1:0] s);
    logic [DATA_W-1:0] r;
    r = s >> 1;
    if (s[0]) r = r ^ FILL_POLY;
    return r;
  endfunction

  assign lfsr_next = fill_step(lfsr_q);

  // fill sequencer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      fill_idx_q <= '0;
      lfsr_q     <= '0;
    end else if (fill_start_i) begin
      busy_q     <= 1'b1;     // busy from the next edge on
      fill_idx_q <= '0;
      lfsr_q     <= seed_i;   // word 0 gets one step from here
    end else if (busy_q) begin
      lfsr_q     <= lfsr_next;
      fill_idx_q <= fill_idx_q + 1'b1;
      if (fill_idx_q == RES_AW'(RES_DEPTH - 1)) busy_q <= 1'b0;  // last word
    end
  end

  // storage, all zero after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < RES_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (busy_q && !fill_start_i) begin
      mem_q[fill_idx_q] <= lfsr_next;  // word k = k+1 steps
    end
  end

  assign fill_busy_o = busy_q;
  assign rd_word_o   = mem_q[rd_idx_i];  // comb read for the emitter

endmodule

`default_nettype wire

//--- src/tgen_cfg_regs.sv
`default_nettype none

module tgen_cfg_regs
  import tgen_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              cfg_we_i,
  input  wire logic [CFG_AW-1:0] cfg_addr_i,
  input  wire logic [DATA_W-1:0] cfg_wdata_i,
  output logic      [DATA_W-1:0] cfg_rdata_o,
  input  wire logic              fill_busy_i,
  input  wire logic              beat_done_i,
  output logic                   enable_o,
  output logic                   no_stall_o,
  output logic      [7:0]        stall_thresh_o,
  output logic      [1:0]        rot_amount_o,
  output logic                   rot_arm_o,
  output logic                   fill_start_o,
  output logic      [DATA_W-1:0] seed_o
);

  logic [BCNT_W-1:0] beat_cnt_q;   // accepted beats, wraps
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;

  // settings and command pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_o       <= 1'b0;
      no_stall_o     <= 1'b0;
      stall_thresh_o <= '0;
      rot_amount_o   <= '0;
      seed_o         <= SEED_INIT;
      fill_start_o   <= 1'b0;
      rot_arm_o      <= 1'b0;
    end else begin
      // one-cycle pulses, the cycle after the write
      fill_start_o <= cfg_we_i && (cfg_addr_i == ADDR_CTRL) && cfg_wdata_i[CTRL_RAND_BIT];
      rot_arm_o    <= cfg_we_i && (cfg_addr_i == ADDR_ROT);
      if (cfg_we_i) begin
        case (cfg_addr_i)
          ADDR_CTRL: begin
            enable_o   <= cfg_wdata_i[CTRL_EN_BIT];
            no_stall_o <= cfg_wdata_i[CTRL_NOST_BIT];
          end
          ADDR_STALL: stall_thresh_o <= cfg_wdata_i[7:0];
          ADDR_ROT:   rot_amount_o   <= cfg_wdata_i[1:0];
          ADDR_SEED:  seed_o         <= cfg_wdata_i;
          default: ;  // status is read only
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) beat_cnt_q <= '0;
    else if (beat_done_i) beat_cnt_q <= beat_cnt_q + 1'b1;
  end

  // readback mux, randomize always reads 0
  always_comb begin
    rdata_d = '0;
    case (cfg_addr_i)
      ADDR_CTRL:   rdata_d[1:0] = {no_stall_o, enable_o};
      ADDR_STALL:  rdata_d[7:0] = stall_thresh_o;
      ADDR_ROT:    rdata_d[1:0] = rot_amount_o;
      ADDR_SEED:   rdata_d      = seed_o;
      ADDR_STATUS: rdata_d      = {beat_cnt_q, {(DATA_W-BCNT_W-1){1'b0}}, fill_busy_i};
      default:     rdata_d      = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) rdata_q <= '0;
    else if (!cfg_we_i) rdata_q <= rdata_d;  // only sampled on reads
  end

  assign cfg_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/tgen_stream_if.sv
`default_nettype none

interface tgen_stream_if
  import tgen_pkg::*;
();

  logic [DATA_W-1:0] data;   // payload
  logic [STRB_W-1:0] strb;   // byte enables
  logic              valid;  // source has a beat
  logic              ready;  // sink takes it

  // emitter side
  modport source (output data, output strb, output valid, input ready);

  // consumer side
  modport sink (input data, input strb, input valid, output ready);

endinterface

`default_nettype wire

//--- src/tgen_pkg.sv
`default_nettype none

package tgen_pkg;

  // stream geometry
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;  // one strobe bit per byte
  localparam int RES_DEPTH = 16;          // reservoir words
  localparam int RES_AW    = 4;           // log2(RES_DEPTH)
  localparam int BCNT_W    = 16;          // accepted-beat counter in status[31:16]

  // register map
  localparam int CFG_AW = 3;
  localparam logic [CFG_AW-1:0] ADDR_CTRL   = 3'd0;  // enable, no_stall, randomize
  localparam logic [CFG_AW-1:0] ADDR_STALL  = 3'd1;  // stall threshold [7:0]
  localparam logic [CFG_AW-1:0] ADDR_ROT    = 3'd2;  // rotation [1:0], write arms
  localparam logic [CFG_AW-1:0] ADDR_SEED   = 3'd3;  // fill seed
  localparam logic [CFG_AW-1:0] ADDR_STATUS = 3'd4;  // read only

  // ctrl bit positions
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_NOST_BIT = 1;
  localparam int CTRL_RAND_BIT = 2;

  // galois lfsr taps, shift right and xor when old lsb set
  localparam logic [DATA_W-1:0] FILL_POLY  = 32'h80200003;
  localparam logic [15:0]       STALL_POLY = 16'hB400;
  localparam logic [15:0]       STALL_INIT = 16'hACE1;  // stall lfsr reset value
  localparam logic [DATA_W-1:0] SEED_INIT  = 32'h1;     // seed reg reset value

endpackage

`default_nettype wire
